// File: src/l2_pkg.sv
package l2_pkg;

	// cache geometry, a 16-bit physical space with 16-byte lines
	localparam int addr_width     = 16;
	localparam int line_width     = 128;
	localparam int offset_width   = 4;  // byte within a line
	localparam int set_width      = 3;
	localparam int tag_width      = addr_width - set_width - offset_width;
	localparam int num_sets       = 1 << set_width;
	localparam int line_num_width = addr_width - offset_width;

	// the same address word seen by the arrays and by the next-line arithmetic
	typedef union packed {
		struct packed {
			logic [tag_width-1:0]    tag;
			logic [set_width-1:0]    set;
			logic [offset_width-1:0] offset;
		} fields;
		struct packed {
			logic [line_num_width-1:0] num;
			logic [offset_width-1:0]   offset;
		} line;
	} l2_addr_t;

	typedef logic [line_width-1:0] l2_line_t;

	// controller states
	typedef enum logic [2:0] {
		idle,
		hit_s,
		prefetch_s,       // install the buffered line
		prefetch_done_s,  // release the buffer
		write_back,
		allocate
	} l2_state_t;

endpackage : l2_pkg

// File: src/l2_tag_lookup.sv
`timescale 1ns/100ps

module l2_tag_lookup (
	input  logic                         clk,
	input  logic                         arst_n,
	input  l2_pkg::l2_addr_t             mem_address,
	input  l2_pkg::l2_addr_t             pf_address,
	input  logic                         prefetch,
	input  logic                         sel_way_mux,
	input  logic                         mem_write,
	input  logic                         real_mem_resp,
	input  logic                         pmem_read,
	input  logic                         pmem_resp,
	output logic                         hit,
	output logic                         dirty,
	output logic                         hit_way,
	output logic                         victim_way,
	output logic [l2_pkg::tag_width-1:0] victim_tag,
	output logic                         pf_present,
	output logic                         pf_victim_dirty
);
	import l2_pkg::*;

	logic [tag_width-1:0]     tags [2][num_sets];
	logic [1:0][num_sets-1:0] valid;
	logic [1:0][num_sets-1:0] dirty_q;
	logic [num_sets-1:0]      lru;  // holds the way to evict next in each set

	l2_addr_t             addr;
	logic [set_width-1:0] set;
	logic [set_width-1:0] pf_set;
	logic [1:0]           match;
	logic [1:0]           pf_match;
	logic                 way_sel;
	logic                 fill;

	// the install cycle looks up the buffered line instead of the request
	assign addr   = prefetch ? pf_address : mem_address;
	assign set    = addr.fields.set;
	assign pf_set = pf_address.fields.set;

	always_comb begin
		for (int w = 0; w < 2; w++) begin
			match[w]    = valid[w][set] && (tags[w][set] == addr.fields.tag);
			pf_match[w] = valid[w][pf_set] && (tags[w][pf_set] == pf_address.fields.tag);
		end
	end

	assign hit             = |match;
	assign hit_way         = match[1];
	assign victim_way      = lru[set];
	assign victim_tag      = tags[victim_way][set];
	assign dirty           = valid[victim_way][set] & dirty_q[victim_way][set];
	assign pf_present      = |pf_match;
	assign pf_victim_dirty = valid[lru[pf_set]][pf_set] & dirty_q[lru[pf_set]][pf_set];

	assign way_sel = sel_way_mux ? victim_way : hit_way;
	assign fill    = prefetch | (sel_way_mux & pmem_read & pmem_resp);  // install or allocate

	always_ff @(posedge clk) begin
		if (fill)
			tags[way_sel][set] <= addr.fields.tag;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid   <= '0;
			dirty_q <= '0;
			lru     <= '0;
		end else begin
			if (fill) begin
				valid[way_sel][set]   <= 1'b1;
				dirty_q[way_sel][set] <= 1'b0;  // a fresh line matches memory
			end
			// every answered hit makes the other way the victim
			if (real_mem_resp && hit) begin
				lru[set] <= ~hit_way;
				if (mem_write)
					dirty_q[hit_way][set] <= 1'b1;
			end
		end
	end

endmodule : l2_tag_lookup

// File: src/l2_cache_control.sv
`timescale 1ns/100ps

module l2_cache_control (
	input  logic clk,
	input  logic arst_n,
	input  logic mem_read,
	input  logic mem_write,
	input  logic hit,
	input  logic dirty,
	input  logic pmem_resp,
	input  logic prefetch_ready,
	input  logic prefetch_busy,
	output logic sel_way_mux,
	output logic pmem_mux_sel,
	output logic ctl_pmem_read,
	output logic pmem_write,
	output logic real_mem_resp,
	output logic no_prefetch,
	output logic done_prefetch,
	output logic prefetch
);
	import l2_pkg::*;

	l2_state_t state;
	l2_state_t next_state;
	logic      req;

	assign req = mem_read | mem_write;

	// outputs depend on the state alone
	always_comb begin
		sel_way_mux   = 1'b0;
		pmem_mux_sel  = 1'b0;
		ctl_pmem_read = 1'b0;
		pmem_write    = 1'b0;
		real_mem_resp = 1'b0;
		no_prefetch   = 1'b0;
		done_prefetch = 1'b0;
		prefetch      = 1'b0;

		case (state)
			hit_s: begin
				real_mem_resp = 1'b1;
			end
			prefetch_s: begin
				sel_way_mux = 1'b1;  // buffer goes into the LRU way
				prefetch    = 1'b1;
			end
			prefetch_done_s: begin
				done_prefetch = 1'b1;
			end
			write_back: begin
				sel_way_mux  = 1'b1;
				pmem_mux_sel = 1'b1;  // address from the victim tag
				pmem_write   = 1'b1;
				no_prefetch  = 1'b1;
			end
			allocate: begin
				sel_way_mux   = 1'b1;
				ctl_pmem_read = 1'b1;
				no_prefetch   = 1'b1;
			end
			default: begin
			end
		endcase
	end

	always_comb begin
		next_state = state;

		unique case (state)
			idle, prefetch_done_s: begin
				// a waiting request wins, the buffer is installed only when the port is quiet
				if (hit && req)
					next_state = hit_s;
				else if (state == idle && prefetch_ready && !req)
					next_state = prefetch_s;
				else if (!prefetch_busy && !hit && req)
					next_state = dirty ? write_back : allocate;
				else
					next_state = idle;
			end

			hit_s: next_state = idle;

			prefetch_s: next_state = prefetch_done_s;

			write_back: begin
				if (!req)
					next_state = idle;      // request withdrawn
				else if (pmem_resp)
					next_state = allocate;
			end

			allocate: begin
				// back to idle so the filled line answers as a hit
				if (!req || pmem_resp)
					next_state = idle;
			end

			default: next_state = idle;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			state <= idle;
		else
			state <= next_state;
	end

endmodule : l2_cache_control

// File: src/l2_line_store.sv
`timescale 1ns/100ps

module l2_line_store (
	input  logic                         clk,
	input  l2_pkg::l2_addr_t             mem_address,
	input  l2_pkg::l2_addr_t             pf_address,
	input  l2_pkg::l2_line_t             mem_wdata,
	input  l2_pkg::l2_line_t             pmem_rdata,
	input  l2_pkg::l2_line_t             pf_line,
	input  logic                         sel_way_mux,
	input  logic                         hit_way,
	input  logic                         victim_way,
	input  logic [l2_pkg::tag_width-1:0] victim_tag,
	input  logic                         pmem_mux_sel,
	input  logic                         prefetch,
	input  logic                         mem_write,
	input  logic                         real_mem_resp,
	input  logic                         ctl_pmem_read,
	input  logic                         pmem_resp,
	output l2_pkg::l2_line_t             mem_rdata,
	output l2_pkg::l2_addr_t             cache_pmem_address,
	output l2_pkg::l2_line_t             pmem_wdata
);
	import l2_pkg::*;

	l2_line_t             data [2][num_sets];
	l2_line_t             wdata;
	logic [set_width-1:0] set;
	logic                 way_sel;
	logic                 we;

	assign set     = prefetch ? pf_address.fields.set : mem_address.fields.set;
	assign way_sel = sel_way_mux ? victim_way : hit_way;

	// one write port, the three sources never coincide
	always_comb begin
		we    = 1'b0;
		wdata = pmem_rdata;
		if (prefetch) begin
			we    = 1'b1;
			wdata = pf_line;
		end else if (ctl_pmem_read && pmem_resp) begin
			we = 1'b1;  // allocate completes
		end else if (real_mem_resp && mem_write) begin
			we    = 1'b1;
			wdata = mem_wdata;
		end
	end

	always_ff @(posedge clk) begin
		if (we)
			data[way_sel][set] <= wdata;
	end

	assign mem_rdata  = data[hit_way][set];
	assign pmem_wdata = data[victim_way][set];  // only meaningful in write-back

	// memory always sees line aligned addresses
	always_comb begin
		cache_pmem_address               = mem_address;
		cache_pmem_address.fields.offset = '0;
		if (pmem_mux_sel)
			cache_pmem_address.fields.tag = victim_tag;
	end

endmodule : l2_line_store

// File: src/l2_next_line_prefetch.sv
`timescale 1ns/100ps

module l2_next_line_prefetch (
	input  logic             clk,
	input  logic             arst_n,
	input  l2_pkg::l2_addr_t mem_address,
	input  l2_pkg::l2_addr_t cache_pmem_address,
	input  logic             ctl_pmem_read,
	input  logic             no_prefetch,
	input  l2_pkg::l2_line_t pmem_rdata,
	input  logic             pmem_resp,
	input  logic             pf_present,
	input  logic             pf_victim_dirty,
	input  logic             done_prefetch,
	output l2_pkg::l2_addr_t pf_address,
	output l2_pkg::l2_line_t pf_line,
	output logic             prefetch_busy,
	output logic             prefetch_ready,
	output logic             pmem_read,
	output l2_pkg::l2_addr_t pmem_address
);
	import l2_pkg::*;

	l2_addr_t next_line;
	logic     full;     // buffer holds a fetched line
	logic     start;
	logic     pf_done;
	logic     drop;

	// the demand read completing is the trigger, memory is free the next cycle
	assign start   = ctl_pmem_read & pmem_resp;
	assign pf_done = prefetch_busy & pmem_resp & ~no_prefetch;

	// a buffered line is useless once it is cached, and never forces a write-back
	assign drop           = full & (pf_present | pf_victim_dirty);
	assign prefetch_ready = full & ~pf_present & ~pf_victim_dirty;

	always_comb begin
		next_line          = '0;
		next_line.line.num = mem_address.line.num + 1'b1;  // wraps at the top of memory
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			prefetch_busy <= 1'b0;
			full          <= 1'b0;
			pf_address    <= '0;
		end else if (start) begin
			prefetch_busy <= 1'b1;
			full          <= 1'b0;  // a new target replaces whatever was held
			pf_address    <= next_line;
		end else if (pf_done) begin
			prefetch_busy <= 1'b0;
			full          <= 1'b1;
		end else if (done_prefetch || drop) begin
			full <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (pf_done)
			pf_line <= pmem_rdata;
	end

	// controller and prefetcher never read at once, so a plain OR is safe
	assign pmem_read    = ctl_pmem_read | prefetch_busy;
	assign pmem_address = prefetch_busy ? pf_address : cache_pmem_address;

endmodule : l2_next_line_prefetch

// File: src/l2_cache.sv
`timescale 1ns/100ps

module l2_cache (
	input  logic             clk,
	input  logic             arst_n,
	input  l2_pkg::l2_addr_t mem_address,
	input  logic             mem_read,
	input  logic             mem_write,
	input  l2_pkg::l2_line_t mem_wdata,
	output l2_pkg::l2_line_t mem_rdata,
	output logic             mem_resp,
	output l2_pkg::l2_addr_t pmem_address,
	output logic             pmem_read,
	output logic             pmem_write,
	output l2_pkg::l2_line_t pmem_wdata,
	input  l2_pkg::l2_line_t pmem_rdata,
	input  logic             pmem_resp
);
	import l2_pkg::*;

	logic                 hit;
	logic                 dirty;
	logic                 hit_way;
	logic                 victim_way;
	logic [tag_width-1:0] victim_tag;
	logic                 pf_present;
	logic                 pf_victim_dirty;
	logic                 sel_way_mux;
	logic                 pmem_mux_sel;
	logic                 ctl_pmem_read;
	logic                 no_prefetch;
	logic                 done_prefetch;
	logic                 prefetch;
	logic                 prefetch_ready;
	logic                 prefetch_busy;
	l2_addr_t             pf_address;
	l2_addr_t             cache_pmem_address;
	l2_line_t             pf_line;

	// mem_resp doubles as the controller's hit response to the arrays
	l2_tag_lookup lookup0 (
		.clk, .arst_n, .mem_address, .pf_address, .prefetch, .sel_way_mux, .mem_write,
		.real_mem_resp(mem_resp), .pmem_read, .pmem_resp, .hit, .dirty, .hit_way,
		.victim_way, .victim_tag, .pf_present, .pf_victim_dirty
	);

	l2_cache_control control0 (
		.clk, .arst_n, .mem_read, .mem_write, .hit, .dirty, .pmem_resp, .prefetch_ready,
		.prefetch_busy, .sel_way_mux, .pmem_mux_sel, .ctl_pmem_read, .pmem_write,
		.real_mem_resp(mem_resp), .no_prefetch, .done_prefetch, .prefetch
	);

	l2_line_store store0 (
		.clk, .mem_address, .pf_address, .mem_wdata, .pmem_rdata, .pf_line, .sel_way_mux,
		.hit_way, .victim_way, .victim_tag, .pmem_mux_sel, .prefetch, .mem_write,
		.real_mem_resp(mem_resp), .ctl_pmem_read, .pmem_resp, .mem_rdata,
		.cache_pmem_address, .pmem_wdata
	);

	// the prefetcher owns the shared read strobe and the address mux
	l2_next_line_prefetch prefetch0 (
		.clk, .arst_n, .mem_address, .cache_pmem_address, .ctl_pmem_read, .no_prefetch,
		.pmem_rdata, .pmem_resp, .pf_present, .pf_victim_dirty, .done_prefetch,
		.pf_address, .pf_line, .prefetch_busy, .prefetch_ready, .pmem_read, .pmem_address
	);

endmodule : l2_cache

// File: testbench/l2_cache_chk.sv
`timescale 1ns/100ps

module l2_cache_chk (
	input logic              clk,
	input logic              arst_n,
	input logic              mem_read,
	input logic              mem_write,
	input logic              mem_resp,
	input logic              pmem_read,
	input logic              pmem_write,
	input logic              pmem_resp,
	input l2_pkg::l2_state_t state
);
	import l2_pkg::*;

	int fail_count = 0;

	assert property (@(posedge clk) disable iff (!arst_n) !(pmem_read && pmem_write))
	else begin
		fail_count++;
		$error("pmem_read and pmem_write are high together");
	end

	// a response only answers a request that is still up
	assert property (@(posedge clk) disable iff (!arst_n)
		mem_resp |-> (mem_read || mem_write))
	else begin
		fail_count++;
		$error("mem_resp is high without a request");
	end

	// the filled line hits in the idle cycle that follows the allocate
	assert property (@(posedge clk) disable iff (!arst_n)
		(state == allocate && pmem_resp && (mem_read || mem_write)) |-> ##2 mem_resp)
	else begin
		fail_count++;
		$error("a completed allocate was not answered as a hit");
	end

	assert property (@(posedge clk) disable iff (!arst_n) (pmem_read && !pmem_resp) |=> pmem_read)
	else begin
		fail_count++;
		$error("pmem_read dropped before pmem_resp");
	end

	assert property (@(posedge clk) disable iff (!arst_n) (pmem_write && !pmem_resp) |=> pmem_write)
	else begin
		fail_count++;
		$error("pmem_write dropped before pmem_resp");
	end

endmodule : l2_cache_chk

bind l2_cache l2_cache_chk chk0 (
	.clk(clk),
	.arst_n(arst_n),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.mem_resp(mem_resp),
	.pmem_read(pmem_read),
	.pmem_write(pmem_write),
	.pmem_resp(pmem_resp),
	.state(control0.state)
);

// File: testbench/l2_cache_tb.sv
`timescale 1ns/100ps

module l2_cache_tb;
	import l2_pkg::*;

	localparam int   clk_period   = 4;
	localparam int   reset_cycles = 5;
	localparam int   mem_latency  = 3;
	localparam int   gap_cycles   = 8;  // room for a prefetch to fetch and install
	localparam int   num_tests    = 12;
	localparam logic op_read      = 1'b0;
	localparam logic op_write     = 1'b1;

	typedef struct packed {
		logic       write;
		l2_addr_t   addr;
		logic [1:0] reads;    // memory reads seen while the request is up
		logic [1:0] writes;
		l2_addr_t   wb_addr;  // where a write-back has to land
	} entry_t;

	localparam entry_t tests [num_tests] = '{
		'{op_read,  16'h1230, 2'd1, 2'd0, 16'h0000},  // cold miss, line 124 gets prefetched
		'{op_read,  16'h1234, 2'd0, 2'd0, 16'h0000},
		'{op_write, 16'h1230, 2'd0, 2'd0, 16'h0000},
		'{op_read,  16'h1238, 2'd0, 2'd0, 16'h0000},
		'{op_read,  16'h1240, 2'd0, 2'd0, 16'h0000},  // answered by the installed prefetch
		// three lines of set 2, the first one left dirty
		'{op_write, 16'h0020, 2'd1, 2'd0, 16'h0000},
		'{op_read,  16'h00a0, 2'd1, 2'd0, 16'h0000},
		'{op_read,  16'h0120, 2'd1, 2'd1, 16'h0020},
		'{op_read,  16'h0020, 2'd1, 2'd0, 16'h0000},
		// line 056 is dirty before the miss on 055 tries to fetch it
		'{op_write, 16'h0560, 2'd1, 2'd0, 16'h0000},
		'{op_read,  16'h0550, 2'd1, 2'd0, 16'h0000},
		'{op_read,  16'h0560, 2'd0, 2'd0, 16'h0000}
	};

	logic     clk = 1'b0;
	logic     arst_n;
	l2_addr_t mem_address;
	logic     mem_read;
	logic     mem_write;
	l2_line_t mem_wdata;
	l2_line_t mem_rdata;
	logic     mem_resp;
	l2_addr_t pmem_address;
	logic     pmem_read;
	logic     pmem_write;
	l2_line_t pmem_wdata;
	l2_line_t pmem_rdata = '0;
	logic     pmem_resp  = 1'b0;

	l2_line_t    mem_lines [logic [line_num_width-1:0]];
	l2_line_t    shadow [logic [line_num_width-1:0]];  // what the requester expects back
	int          wait_count   = 0;
	int          rd_count     = 0;
	int          wr_count     = 0;
	l2_addr_t    last_wr_addr = '0;
	l2_line_t    last_wr_data = '0;
	logic [31:0] lfsr         = 32'hf074;
	int          checks       = 0;
	int          errors       = 0;

	l2_cache dut0 (
		.clk, .arst_n, .mem_address, .mem_read, .mem_write, .mem_wdata, .mem_rdata,
		.mem_resp, .pmem_address, .pmem_read, .pmem_write, .pmem_wdata, .pmem_rdata,
		.pmem_resp
	);

	always #(clk_period / 2) clk = ~clk;

	// a line never written holds its own line number over and over
	function automatic l2_line_t line_pattern(input logic [line_num_width-1:0] num);
		logic [11*line_num_width-1:0] r;
		r = {11{num}};
		return r[line_width-1:0];
	endfunction

	function automatic l2_line_t stored_line(input logic [line_num_width-1:0] num);
		return mem_lines.exists(num) ? mem_lines[num] : line_pattern(num);
	endfunction

	function automatic l2_line_t expected_line(input logic [line_num_width-1:0] num);
		return shadow.exists(num) ? shadow[num] : line_pattern(num);
	endfunction

	// taps 32, 22, 2 and 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic l2_line_t random_line();
		l2_line_t v;
		for (int i = 0; i < line_width; i++) begin
			lfsr = lfsr_next(lfsr);
			v[i] = lfsr[0];
		end
		return v;
	endfunction

	task automatic check_line(input string name, input l2_line_t got, input l2_line_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_addr(input string name, input l2_addr_t got, input l2_addr_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %s got %h expected %h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("error %s got %0h expected %0h", name, got, exp);
		end
	endtask

	// memory answers on the third falling edge that sees a strobe
	always @(negedge clk) begin
		if (pmem_resp) begin
			pmem_resp  <= 1'b0;
			wait_count <= 0;
		end else if (pmem_read || pmem_write) begin
			if (wait_count == mem_latency - 1) begin
				pmem_resp <= 1'b1;
				if (pmem_write) begin
					mem_lines[pmem_address.line.num] = pmem_wdata;
					wr_count     <= wr_count + 1;
					last_wr_addr <= pmem_address;
					last_wr_data <= pmem_wdata;
				end else begin
					pmem_rdata <= stored_line(pmem_address.line.num);
					rd_count   <= rd_count + 1;
				end
			end else begin
				wait_count <= wait_count + 1;
			end
		end
	end

	task automatic run_entry(input entry_t e);
		int       rd_start;
		int       wr_start;
		l2_line_t exp_line;
		l2_line_t got_line;
		rd_start = rd_count;
		wr_start = wr_count;
		exp_line = expected_line(e.addr.line.num);
		mem_address = e.addr;
		if (e.write) begin
			exp_line  = random_line();
			mem_wdata = exp_line;
			mem_write = 1'b1;
		end else begin
			mem_read = 1'b1;
		end
		do @(negedge clk); while (!mem_resp);
		got_line = mem_rdata;
		@(negedge clk);  // held across the edge that takes the response
		mem_read  = 1'b0;
		mem_write = 1'b0;
		if (e.write)
			shadow[e.addr.line.num] = exp_line;
		else
			check_line("mem_rdata", got_line, exp_line);
		check_count("memory reads", rd_count - rd_start, int'(e.reads));
		check_count("memory writes", wr_count - wr_start, int'(e.writes));
		if (e.writes != 0) begin
			check_addr("pmem_address", last_wr_addr, e.wb_addr);
			check_line("pmem_wdata", last_wr_data, expected_line(e.wb_addr.line.num));
		end
	endtask

	initial begin
		arst_n      = 1'b0;
		mem_address = '0;
		mem_read    = 1'b0;
		mem_write   = 1'b0;
		mem_wdata   = '0;
		repeat (reset_cycles) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		check_bit("mem_resp", mem_resp, 1'b0);
		check_bit("pmem_read", pmem_read, 1'b0);
		check_bit("pmem_write", pmem_write, 1'b0);
		foreach (tests[i]) begin
			run_entry(tests[i]);
			repeat (gap_cycles) @(negedge clk);
		end
		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors,
			dut0.chk0.fail_count);
		if (errors == 0 && dut0.chk0.fail_count == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin
		#((num_tests * 400 + reset_cycles) * clk_period);
		$display("timeout, the requests did not all complete in time");
		$display("Checks failed");
		$finish;
	end

endmodule : l2_cache_tb

// File: sources.f
src/l2_pkg.sv
src/l2_tag_lookup.sv
src/l2_cache_control.sv
src/l2_line_store.sv
src/l2_next_line_prefetch.sv
src/l2_cache.sv
testbench/l2_cache_chk.sv
testbench/l2_cache_tb.sv

// File: Bender.yml
package:
  name: l2_cache

sources:
  - files:
      - src/l2_pkg.sv
      - src/l2_tag_lookup.sv
      - src/l2_cache_control.sv
      - src/l2_line_store.sv
      - src/l2_next_line_prefetch.sv
      - src/l2_cache.sv
  - target: test
    files:
      - testbench/l2_cache_chk.sv
      - testbench/l2_cache_tb.sv
